// ==== Bender.yml ====
package:
  name: spec_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/spec_pkg.sv
      - hdl/branch_buffer.sv
      - hdl/rename_table.sv
      - hdl/spec_unit_top.sv
      - target: simulation
        files:
          - sim/spec_unit_properties.sv
          - sim/spec_unit_tb.sv

// ==== hdl/branch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spec_defines.svh"

module branch_buffer import spec_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    // Decode side
    input  logic    dec_valid,       // One instruction per cycle
    input  opcode_t opcode,
    input  pc_t     pc,
    // Resolve side, in program order
    input  logic    res_valid,
    input  pc_t     res_pc,
    input  logic    mispredict,      // Head branch went the wrong way
    // To rename table
    output logic    checkpoint,      // One-cycle pulse
    output bb_tag_t checkpoint_tag,
    output logic    restore,         // One-cycle pulse
    output bb_tag_t restore_tag,
    output logic    bb_full          // Stall decode of branches
);

    localparam logic [`BB_PTR_W:0] DEPTH = `BB_DEPTH;  // Full compare value

    pc_t                pc_mem [`BB_DEPTH];   // Unresolved branch PCs
    bb_tag_t            head;                 // Oldest branch
    bb_tag_t            tail;                 // Next free slot
    logic [`BB_PTR_W:0] count;                // Occupancy, 0..DEPTH

    logic is_branch;     // Opcode needs a checkpoint
    logic bb_empty;
    logic head_hit;      // Resolve matches the oldest entry
    logic flush;         // Mispredict on head
    logic retire;        // Correct resolve on head
    logic push;          // Accept new branch

    // Only conditional branches and jalr can mispredict
    assign is_branch = (opcode == `OP_BRANCH) || (opcode == `OP_JALR);

    assign bb_full  = (count == DEPTH);
    assign bb_empty = (count == '0);

    // Resolves come in order, so only the head is compared
    assign head_hit = res_valid && !bb_empty && (pc_mem[head] == res_pc);
    assign flush    = head_hit && mispredict;
    assign retire   = head_hit && !mispredict;

    // Mispredict wins over a decode in the same cycle
    assign push = dec_valid && is_branch && !bb_full && !flush;

    // PC storage, payload only
    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[tail] <= pc;
        end
    end

    // Pointers and occupancy
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // Everything younger is on the wrong path
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + bb_tag_t'(1);  // Wraps at depth
            end
            if (retire) begin
                head <= head + bb_tag_t'(1);
            end
            case ({push, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Both or neither
            endcase
        end
    end

    // Registered pulses to the rename table
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            checkpoint     <= 1'b0;
            checkpoint_tag <= '0;
            restore        <= 1'b0;
            restore_tag    <= '0;
        end else begin
            checkpoint <= push;              // Cycle after decode
            restore    <= flush;             // Cycle after resolve
            if (push) begin
                checkpoint_tag <= tail;      // Slot just written
            end
            if (flush) begin
                restore_tag <= head;         // Slot of the failed branch
            end
        end
    end

endmodule : branch_buffer

`default_nettype wire

// ==== hdl/rename_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spec_defines.svh"

module rename_table import spec_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    // Decode side
    input  logic    dec_valid,
    input  opcode_t opcode,
    input  areg_t   rd,
    input  areg_t   rs1,
    input  areg_t   rs2,
    // Combinational rename results
    output preg_t   rd_preg,         // New tag, or current one if no write
    output preg_t   rs1_preg,
    output preg_t   rs2_preg,
    // From branch buffer
    input  logic    checkpoint,
    input  bb_tag_t checkpoint_tag,
    input  logic    restore,
    input  bb_tag_t restore_tag
);

    localparam preg_t FIRST_FREE = preg_t'(`AREG_NUM);  // Tags above the identity map

    preg_t map       [`AREG_NUM];                 // Speculative map
    preg_t alloc_cnt;                             // Next tag to hand out

    preg_t cp_map    [`BB_DEPTH][`AREG_NUM];      // Saved maps per slot
    preg_t cp_cnt    [`BB_DEPTH];                 // Saved counters per slot

    logic  writes_rd;                             // Decode needs a new tag

    // Branches and stores have no destination, x0 is hardwired
    assign writes_rd = dec_valid
                     && (opcode != `OP_BRANCH)
                     && (opcode != `OP_STORE)
                     && (rd != '0);

    // Source lookups see the map before this decode's own write
    assign rs1_preg = map[rs1];
    assign rs2_preg = map[rs2];

    assign rd_preg = writes_rd ? alloc_cnt : map[rd];

    // Map and allocator
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `AREG_NUM; i++) begin
                map[i] <= preg_t'(i);        // Identity after reset
            end
            alloc_cnt <= FIRST_FREE;
        end else if (restore) begin
            // Roll back to the state at the failed branch
            map       <= cp_map[restore_tag];
            alloc_cnt <= cp_cnt[restore_tag];
        end else if (writes_rd) begin
            map[rd]   <= alloc_cnt;
            alloc_cnt <= alloc_cnt + preg_t'(1);  // Wraps in tag range
        end
    end

    // Checkpoint slots, written one cycle after the branch decode,
    // so the snapshot already holds a jalr's own rd mapping
    always_ff @(posedge clk) begin
        if (checkpoint) begin
            cp_map[checkpoint_tag] <= map;
            cp_cnt[checkpoint_tag] <= alloc_cnt;
        end
    end

endmodule : rename_table

`default_nettype wire

// ==== hdl/spec_defines.svh ====
`ifndef SPEC_DEFINES_SVH
`define SPEC_DEFINES_SVH

// Branch buffer geometry
`define BB_DEPTH 8                // Entries, also checkpoint slots
`define BB_PTR_W 3                // Slot index width

// Register file sizes
`define AREG_NUM 32               // Architectural registers
`define PREG_W   6                // Physical tag width, 64 tags

// RV32I major opcodes
`define OP_BRANCH 7'b1100011      // beq, bne, blt and friends
`define OP_JALR   7'b1100111      // Indirect jump, can mispredict
`define OP_STORE  7'b0100011      // No rd write

`endif // SPEC_DEFINES_SVH

// ==== hdl/spec_pkg.sv ====
`default_nettype none

`include "spec_defines.svh"

package spec_pkg;

    // Program counter, full RV32 width
    typedef logic [31:0] pc_t;

    // Major opcode field instr[6:0]
    typedef logic [6:0] opcode_t;

    // Architectural register number
    typedef logic [4:0] areg_t;

    // Physical register tag
    typedef logic [`PREG_W-1:0] preg_t;

    // Branch buffer slot, same index as checkpoint slot
    typedef logic [`BB_PTR_W-1:0] bb_tag_t;

endpackage : spec_pkg

`default_nettype wire

// ==== hdl/spec_unit_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module spec_unit_top import spec_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    // Decode
    input  logic    dec_valid,
    input  opcode_t opcode,
    input  pc_t     pc,
    input  areg_t   rd,
    input  areg_t   rs1,
    input  areg_t   rs2,
    // Resolve
    input  logic    res_valid,
    input  pc_t     res_pc,
    input  logic    mispredict,
    // Rename results
    output preg_t   rd_preg,
    output preg_t   rs1_preg,
    output preg_t   rs2_preg,
    // Speculation control, also seen outside
    output logic    checkpoint,
    output bb_tag_t checkpoint_tag,
    output logic    restore,
    output bb_tag_t restore_tag,
    output logic    bb_full          // Decode must stall branches
);

    // Ordered branch store, source of both pulses
    branch_buffer u_branch_buffer (
        .clk            (clk),
        .rst            (rst),
        .dec_valid      (dec_valid),
        .opcode         (opcode),
        .pc             (pc),
        .res_valid      (res_valid),
        .res_pc         (res_pc),
        .mispredict     (mispredict),
        .checkpoint     (checkpoint),
        .checkpoint_tag (checkpoint_tag),
        .restore        (restore),
        .restore_tag    (restore_tag),
        .bb_full        (bb_full)
    );

    // Map with per-branch snapshots
    rename_table u_rename_table (
        .clk            (clk),
        .rst            (rst),
        .dec_valid      (dec_valid),
        .opcode         (opcode),
        .rd             (rd),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd_preg        (rd_preg),
        .rs1_preg       (rs1_preg),
        .rs2_preg       (rs2_preg),
        .checkpoint     (checkpoint),
        .checkpoint_tag (checkpoint_tag),
        .restore        (restore),
        .restore_tag    (restore_tag)
    );

endmodule : spec_unit_top

`default_nettype wire

// ==== sim/spec_unit_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module spec_unit_properties import spec_pkg::*; (
    input wire logic    clk,
    input wire logic    rst,
    input wire logic    dec_valid,
    input wire logic    bb_full,
    input wire logic    checkpoint,
    input wire bb_tag_t checkpoint_tag,
    input wire logic    restore
);

    int unsigned fail_cnt = 0;          // Failed assertions so far

    // Both pulses at once would mean snapshot and rollback in one edge
    pulse_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(checkpoint && restore)) else begin
        fail_cnt++;
        $error("checkpoint and restore together");
    end

    // Decode while full must be dropped
    no_cp_when_full: assert property (@(posedge clk) disable iff (rst)
        (dec_valid && bb_full) |=> !checkpoint) else begin
        fail_cnt++;
        $error("checkpoint after full decode");
    end

    // Back-to-back checkpoints are fine, but never twice for one slot
    cp_one_cycle: assert property (@(posedge clk) disable iff (rst)
        checkpoint |=> (!checkpoint || checkpoint_tag != $past(checkpoint_tag))) else begin
        fail_cnt++;
        $error("checkpoint held for a slot");
    end

    rs_one_cycle: assert property (@(posedge clk) disable iff (rst)
        restore |=> !restore) else begin
        fail_cnt++;
        $error("restore held");
    end

    quiet_in_reset: assert property (@(posedge clk)
        rst |-> (!checkpoint && !restore)) else begin
        fail_cnt++;
        $error("pulse during reset");
    end

endmodule : spec_unit_properties

bind spec_unit_top spec_unit_properties props0 (
    .clk            (clk),
    .rst            (rst),
    .dec_valid      (dec_valid),
    .bb_full        (bb_full),
    .checkpoint     (checkpoint),
    .checkpoint_tag (checkpoint_tag),
    .restore        (restore)
);

`default_nettype wire

// ==== sim/spec_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "spec_defines.svh"

module spec_unit_tb import spec_pkg::*; ();

    localparam opcode_t OP_IMM   = 7'b0010011;   // addi and friends write rd
    localparam int RAND_STEPS     = 300;
    localparam int RESET_CYCLES   = 10;                                     // One apply_reset call
    localparam int TEST_CYCLES    = 32 + 10 + 18 + 6 + 9 + RAND_STEPS + 1;  // Clocks per test
    localparam int TIMEOUT_CYCLES = 2 * (4 * RESET_CYCLES + TEST_CYCLES);

    logic clk, rst, dec_valid, res_valid, mispredict;
    opcode_t opcode;
    pc_t pc, res_pc;
    areg_t rd, rs1, rs2;
    preg_t rd_preg, rs1_preg, rs2_preg;
    logic checkpoint, restore, bb_full;
    bb_tag_t checkpoint_tag, restore_tag;

    // Reference model state
    preg_t   m_map [32];
    preg_t   m_cnt;
    preg_t   m_cp_map [`BB_DEPTH][32];
    preg_t   m_cp_cnt [`BB_DEPTH];
    pc_t     m_bq [$];                  // Unresolved branch PCs in program order
    bb_tag_t m_head, m_tail;
    logic    p_cp, p_rs;                // Pulses due after the next edge
    bb_tag_t p_cp_tag, p_rs_tag;
    string   cur_test;

    spec_unit_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;          // 8 ns period
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: simulation did not finish in %0d cycles", TIMEOUT_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    // Bound assertions count their failures
    initial begin
        wait (dut0.props0.fail_cnt != 0);
        $display("An assertion in spec_unit_properties failed in test %s", cur_test);
        $display("ERRORS FOUND");
        $fatal(1, "assertion failed");
    end

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("** Error test %s, %s: expected %0h actual %0h",
                     cur_test, what, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic drive_idle();
        dec_valid = 1'b0;
        opcode = OP_IMM;
        pc = '0;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        res_valid = 1'b0;
        res_pc = '0;
        mispredict = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        drive_idle();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 32; i++) m_map[i] = preg_t'(i);   // Identity map
        m_cnt = preg_t'(32);
        m_bq.delete();
        m_head = '0;
        m_tail = '0;
        p_cp = 1'b0;
        p_rs = 1'b0;
    endtask

    // Checks and drives one clock, then steps the model for the coming edge
    task automatic run_cycle(input logic dv, input opcode_t op, input pc_t p, input areg_t d,
                             input areg_t s1, input areg_t s2, input logic rv, input pc_t rp,
                             input logic mp);
        logic writes, is_br, full, flush, push, retire;
        @(negedge clk);
        check_val("checkpoint", p_cp, checkpoint);
        if (p_cp) check_val("checkpoint_tag", p_cp_tag, checkpoint_tag);
        check_val("restore", p_rs, restore);
        if (p_rs) check_val("restore_tag", p_rs_tag, restore_tag);
        dec_valid = dv;
        opcode = op;
        pc = p;
        rd = d;
        rs1 = s1;
        rs2 = s2;
        res_valid = rv;
        res_pc = rp;
        mispredict = mp;
        #1;
        writes = dv && op != `OP_BRANCH && op != `OP_STORE && d != 0;
        is_br  = op == `OP_BRANCH || op == `OP_JALR;
        full   = m_bq.size() == `BB_DEPTH;
        check_val("rs1_preg", m_map[s1], rs1_preg);
        check_val("rs2_preg", m_map[s2], rs2_preg);
        check_val("rd_preg", writes ? m_cnt : m_map[d], rd_preg);
        check_val("bb_full", full, bb_full);
        if (p_cp) begin                                     // Snapshot before this edge's write
            for (int i = 0; i < 32; i++) m_cp_map[p_cp_tag][i] = m_map[i];
            m_cp_cnt[p_cp_tag] = m_cnt;
        end
        if (p_rs) begin
            for (int i = 0; i < 32; i++) m_map[i] = m_cp_map[p_rs_tag][i];
            m_cnt = m_cp_cnt[p_rs_tag];
        end else if (writes) begin
            m_map[d] = m_cnt;
            m_cnt = m_cnt + preg_t'(1);                     // Wraps at 64
        end
        flush  = rv && m_bq.size() > 0 && m_bq[0] == rp && mp;
        retire = rv && m_bq.size() > 0 && m_bq[0] == rp && !mp;
        push   = dv && is_br && !full && !flush;
        p_cp = push;
        p_cp_tag = m_tail;
        p_rs = flush;
        p_rs_tag = m_head;
        if (flush) begin
            m_bq.delete();
            m_head = '0;
            m_tail = '0;
        end else begin
            if (push) begin
                m_bq.push_back(p);
                m_tail++;
            end
            if (retire) begin
                void'(m_bq.pop_front());
                m_head++;
            end
        end
    endtask

    task automatic idle_cycle();
        run_cycle(0, OP_IMM, 0, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic test_reset_state();
        cur_test = "reset_state";
        apply_reset();
        for (int r = 0; r < 32; r++) begin
            run_cycle(0, OP_IMM, 0, 0, areg_t'(r), areg_t'(31 - r), 0, 0, 0);
            check_val("identity", r, rs1_preg);              // Independent of the model
        end
    endtask

    task automatic test_alloc();
        cur_test = "alloc";
        for (int r = 1; r <= 5; r++) begin
            run_cycle(1, OP_IMM, 32'h40 + 4 * r, areg_t'(r), 0, 0, 0, 0, 0);
            check_val("new tag", 31 + r, rd_preg);          // 32 upward
        end
        run_cycle(1, OP_IMM, 32'h60, 0, 1, 2, 0, 0, 0);      // x0 write
        run_cycle(1, `OP_STORE, 32'h64, 7, 3, 4, 0, 0, 0);
        run_cycle(1, `OP_BRANCH, 32'h68, 9, 5, 1, 0, 0, 0);
        run_cycle(1, OP_IMM, 32'h6c, 6, 1, 5, 1, 32'h68, 0);  // Resolve branch
        check_val("after skips", 37, rd_preg);
        idle_cycle();
    endtask

    task automatic test_fill();
        cur_test = "fill";
        apply_reset();
        for (int i = 0; i < 8; i++) begin
            run_cycle(1, `OP_BRANCH, 32'h100 + 4 * i, 0, 0, 0, 0, 0, 0);
            idle_cycle();                                   // Pulse checked here
            check_val("cp tag", i, checkpoint_tag);
        end
        run_cycle(1, `OP_BRANCH, 32'h120, 0, 0, 0, 0, 0, 0);  // Dropped
        idle_cycle();
    endtask

    task automatic test_resolve();
        cur_test = "resolve";
        run_cycle(0, OP_IMM, 0, 0, 0, 0, 1, 32'hdead, 0);    // No match
        for (int i = 0; i < 4; i++) run_cycle(0, OP_IMM, 0, 0, 0, 0, 1, m_bq[0], 0);
        idle_cycle();
        check_val("full fell", 0, bb_full);
    endtask

    task automatic test_mispredict();
        cur_test = "mispredict";
        apply_reset();
        run_cycle(1, OP_IMM, 32'h200, 1, 0, 0, 0, 0, 0);
        run_cycle(1, `OP_JALR, 32'h204, 5, 1, 0, 0, 0, 0);  // Own rd is in snapshot
        run_cycle(1, OP_IMM, 32'h208, 2, 0, 0, 0, 0, 0);
        run_cycle(1, OP_IMM, 32'h20c, 1, 0, 0, 0, 0, 0);
        run_cycle(1, `OP_BRANCH, 32'h210, 0, 0, 0, 1, 32'h204, 1);  // Mispredict wins
        idle_cycle();
        idle_cycle();
        run_cycle(1, OP_IMM, 32'h300, 3, 1, 5, 0, 0, 0);
        check_val("saved r1", 32, rs1_preg);
        check_val("saved r5", 33, rs2_preg);
        check_val("resumed cnt", 34, rd_preg);
        idle_cycle();
    endtask

    task automatic test_random();
        int hold;
        logic dv, rv, mp;
        opcode_t op;
        pc_t rp;
        cur_test = "random";
        apply_reset();
        hold = 0;
        for (int n = 0; n < RAND_STEPS; n++) begin
            case ($urandom % 4)
                0: op = `OP_BRANCH;
                1: op = `OP_JALR;
                2: op = `OP_STORE;
                default: op = OP_IMM;
            endcase
            dv = hold == 0 && ($urandom % 4 != 0);
            if ((op == `OP_BRANCH || op == `OP_JALR) && m_bq.size() == `BB_DEPTH) dv = 1'b0;
            rv = m_bq.size() > 0 && ($urandom % 3 == 0);
            rp = (rv && $urandom % 5 != 0) ? m_bq[0] : pc_t'($urandom);
            mp = $urandom % 4 == 0;
            if (hold > 0) hold--;
            run_cycle(dv, op, pc_t'($urandom), areg_t'($urandom), areg_t'($urandom),
                      areg_t'($urandom), rv, rp, mp);
            if (p_rs) hold = 2;                             // Front-end flush window
        end
        idle_cycle();
    endtask

    initial begin
        void'($urandom(99));
        rst = 1'b1;
        drive_idle();
        test_reset_state();
        test_alloc();
        test_fill();
        test_resolve();
        test_mispredict();
        test_random();
        if (dut0.props0.fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : spec_unit_tb

`default_nettype wire

// ==== spec_unit_top.f ====
+incdir+hdl
hdl/spec_pkg.sv
hdl/branch_buffer.sv
hdl/rename_table.sv
hdl/spec_unit_top.sv
sim/spec_unit_properties.sv
sim/spec_unit_tb.sv
